//--- imgConv.f
rtl/convPkg.sv
rtl/gpioCmdPkg.sv
rtl/controlBlock.sv
rtl/pixelBuffer.sv
rtl/convEngine.sv
rtl/imgConvTop.sv
tests/imgConv_assertions.sv
tests/imgConvTb.sv

//--- tests/imgConvTb.sv
`default_nettype none
`timescale 1ns/100ps

module imgConvTb;
  import gpioCmdPkg::*;
  import convPkg::*;

  // About 5000 cycles of host traffic, four-fold margin
  localparam int MAX_CYCLES = 20000;
  // Spare code, decodes to nothing
  localparam logic [CMD_W-1:0] CMD_IDLE = 3'd7;

  logic               clk;
  logic               rst;
  logic [CMD_W-1:0]   gpioCtrl;
  logic               gpioValid;
  logic [DATA_W-1:0]  gpioDataIn;
  logic [RDATA_W-1:0] gpioDataOut;
  logic [2:0]         led;
  logic               eopMcu;
  // Readback check, delayed two cycles like the DUT
  logic               chkOn;
  logic               chkD1;
  logic               chkD2;
  logic [RDATA_W-1:0] expVal;
  logic [RDATA_W-1:0] expD1;
  logic [RDATA_W-1:0] expD2;
  // Reference model state
  logic [PIX_W-1:0]   modelPix [DEPTH];
  logic [RES_W-1:0]   modelRes [DEPTH];
  logic [TAP_W-1:0]   modelTap [N_TAPS];
  logic [31:0]        lcgState;
  int                 errCnt;
  int                 testErrBase;
  int                 testsRun;
  int                 testsBad;
  int                 cycCnt;
  string              curTest;

  imgConvTop DUT (
    .i_CLK(clk), .i_rst(rst),
    .i_GPIOctrl(gpioCtrl), .i_GPIOvalid(gpioValid), .i_GPIOdata(gpioDataIn),
    .o_GPIOdata(gpioDataOut), .o_led(led), .o_EoP_MCU(eopMcu)
  );

  bind controlBlock imgConv_assertions protChk (
    .i_CLK(i_CLK), .i_rst(i_rst), .i_pixWrEn(o_pixWrEn), .i_kernelValid(o_kernelValid),
    .i_sop(o_sop), .i_done(o_EoP_MCU), .i_eop(i_eop)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycCnt = 0;
    while (cycCnt < MAX_CYCLES) begin
      @(posedge clk);
      cycCnt++;
    end
    $display("Timeout: DUT did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  always @(posedge clk) begin
    if (rst) begin
      chkD1 <= 1'b0;
      chkD2 <= 1'b0;
    end else begin
      chkD1 <= chkOn;
      chkD2 <= chkD1;
    end
    expD1 <= expVal;
    expD2 <= expD1;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  readbackOk: assert property (@(posedge clk) disable iff (rst) chkD2 |-> (gpioDataOut == expD2))
    else begin
      errCnt++;
      $display("Fail %s: expected %0h, actual %0h", curTest, $sampled(expD2),
        $sampled(gpioDataOut));
    end

  // Running may only drop together with done rising
  runHeld: assert property (@(posedge clk) disable iff (rst) $fell(led[0]) |-> eopMcu)
    else begin
      errCnt++;
      $display("Running flag dropped before done was set in %s", curTest);
    end

  task automatic expectBit(input string what, input logic exp, input logic act);
    assert (act === exp)
      else begin
        errCnt++;
        $display("Fail %s %s: expected %0b, actual %0b", curTest, what, exp, act);
      end
  endtask

  function automatic int totalErrors();
    return errCnt + int'(DUT.ctrlBlk.protChk.failCnt);
  endfunction

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  ////////////////////////////////////////
  // Host emulation
  ////////////////////////////////////////

  // Inputs change 1 ns after the edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic hostWrite(input logic [CMD_W-1:0] cmd, input logic [DATA_W-1:0] data);
    gpioCtrl   = cmd;
    gpioDataIn = data;
    gpioValid  = 1'b1;
    tick(2);
    gpioValid  = 1'b0;
    tick(2);
  endtask

  task automatic readResult(input int addr, input logic [RDATA_W-1:0] exp);
    gpioCtrl   = CMD_DATA_REQ;
    gpioDataIn = DATA_W'(addr);
    expVal     = exp;
    chkOn      = 1'b1;
    gpioValid  = 1'b1;
    tick(1);
    chkOn      = 1'b0;
    tick(1);
    gpioValid  = 1'b0;
    tick(2);
  endtask

  task automatic echoData(input logic [DATA_W-1:0] data);
    gpioCtrl   = CMD_IDLE;
    gpioDataIn = data;
    expVal     = {{(RDATA_W-DATA_W){1'b0}}, data};
    chkOn      = 1'b1;
    tick(1);
    chkOn      = 1'b0;
    tick(3);
  endtask

  task automatic loadKernel(input logic [TAP_W-1:0] t0, t1, t2);
    modelTap[0] = t0;
    modelTap[1] = t1;
    modelTap[2] = t2;
    hostWrite(CMD_KERNEL_LOAD, {t2, t1, t0});
  endtask

  task automatic loadImage(input int len);
    hostWrite(CMD_SIZE_LOAD, DATA_W'(len));
    for (int i = 0; i < len; i++) begin
      hostWrite(CMD_IMG_LOAD, DATA_W'(modelPix[i]));
    end
  endtask

  // Three-tap sum, tap 0 on the oldest pixel, then scaled
  task automatic buildModel(input int len);
    int sum;
    for (int n = 0; n + 2 < len; n++) begin
      sum = modelTap[0] * modelPix[n] + modelTap[1] * modelPix[n+1]
          + modelTap[2] * modelPix[n+2];
      modelRes[n] = RES_W'(sum >> RES_SHIFT);
    end
  endtask

  task automatic waitDone();
    while (eopMcu !== 1'b1) begin
      tick(1);
    end
  endtask

  task automatic readResults(input int count);
    for (int a = 0; a < count; a++) begin
      readResult(a, RDATA_W'(modelRes[a]));
    end
  endtask

  task automatic beginTest(input string name);
    curTest     = name;
    testErrBase = totalErrors();
  endtask

  task automatic endTest();
    int n;
    n = totalErrors() - testErrBase;
    testsRun++;
    if (n != 0) begin
      testsBad++;
    end
    $display("%s: %0d errors", curTest, n);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    gpioCtrl   = CMD_IDLE;
    gpioValid  = 1'b0;
    gpioDataIn = '0;
    chkOn      = 1'b0;
    expVal     = '0;
    errCnt     = 0;
    testsRun   = 0;
    testsBad   = 0;
    lcgState   = 32'h7979_8ba8;
    curTest    = "reset";
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    tick(1);

    beginTest("reset state");
    expectBit("done", 1'b0, eopMcu);
    expectBit("led running", 1'b0, led[0]);
    expectBit("led done", 1'b0, led[1]);
    expectBit("led kernel mode", 1'b1, led[2]);
    endTest();

    beginTest("ramp 16");
    for (int i = 0; i < 16; i++) begin
      modelPix[i] = PIX_W'(16 * i + 5);
    end
    loadKernel(8'd1, 8'd2, 8'd1);
    loadImage(16);
    buildModel(16);
    hostWrite(CMD_START, '0);
    waitDone();
    readResults(14);
    endTest();

    beginTest("random 300");
    loadKernel(TAP_W'(nextRandom() >> 24), TAP_W'(nextRandom() >> 24),
      TAP_W'(nextRandom() >> 24));
    for (int i = 0; i < 300; i++) begin
      modelPix[i] = PIX_W'(nextRandom() >> 24);
    end
    loadImage(300);
    buildModel(300);
    hostWrite(CMD_START, '0);
    expectBit("led running", 1'b1, led[0]);
    waitDone();
    expectBit("led running", 1'b0, led[0]);
    readResults(298);
    endTest();

    // Kernel and pixels sent mid-run are dropped
    beginTest("commands while running");
    // Write pointer back to 0 so stray pixels would hit the image
    hostWrite(CMD_SIZE_LOAD, DATA_W'(300));
    hostWrite(CMD_START, '0);
    expectBit("led running", 1'b1, led[0]);
    hostWrite(CMD_KERNEL_LOAD, DATA_W'(nextRandom()));
    for (int i = 0; i < 3; i++) begin
      hostWrite(CMD_IMG_LOAD, DATA_W'(nextRandom() >> 24));
    end
    waitDone();
    readResults(298);
    // Second pass rereads the first pixels
    hostWrite(CMD_START, '0);
    waitDone();
    readResults(3);
    endTest();

    beginTest("short image");
    // Kernel load clears done, the short run has to set it again
    hostWrite(CMD_KERNEL_LOAD, '0);
    hostWrite(CMD_SIZE_LOAD, DATA_W'(2));
    hostWrite(CMD_START, '0);
    waitDone();
    expectBit("led running", 1'b0, led[0]);
    readResults(20);
    endTest();

    beginTest("data echo");
    for (int i = 0; i < 4; i++) begin
      echoData(DATA_W'(nextRandom()));
    end
    endTest();

    $display("Summary: %0d tests, %0d with errors, %0d check failures",
      testsRun, testsBad, totalErrors());
    if (totalErrors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/imgConv_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module imgConv_assertions (
  input logic i_CLK,
  input logic i_rst,
  input logic i_pixWrEn,
  input logic i_kernelValid,
  input logic i_sop,
  input logic i_done,
  input logic i_eop
);

  // Protocol violations seen so far
  int unsigned failCnt;

  initial failCnt = 0;

  ////////////////////////////////////////
  // Strobes last a single cycle
  ////////////////////////////////////////

  pixWrPulse: assert property (@(posedge i_CLK) disable iff (i_rst) i_pixWrEn |=> !i_pixWrEn)
    else begin
      failCnt++;
      $error("pixel write strobe held for two cycles");
    end

  kernelPulse: assert property (@(posedge i_CLK) disable iff (i_rst)
    i_kernelValid |=> !i_kernelValid)
    else begin
      failCnt++;
      $error("kernel valid strobe held for two cycles");
    end

  ////////////////////////////////////////
  // Run and done flags
  ////////////////////////////////////////

  // Running and done are exclusive
  runDoneExcl: assert property (@(posedge i_CLK) disable iff (i_rst) !(i_sop && i_done))
    else begin
      failCnt++;
      $error("start of process and done flag high together");
    end

  // End of process only inside a run
  eopInRun: assert property (@(posedge i_CLK) disable iff (i_rst) i_eop |-> i_sop)
    else begin
      failCnt++;
      $error("end of process strobe outside a run");
    end

endmodule

`default_nettype wire

//--- rtl/imgConvTop.sv
`default_nettype none
`timescale 1ns/100ps

module imgConvTop (
  input  logic                           i_CLK,
  input  logic                           i_rst,
  input  logic [gpioCmdPkg::CMD_W-1:0]   i_GPIOctrl,
  input  logic                           i_GPIOvalid,
  input  logic [gpioCmdPkg::DATA_W-1:0]  i_GPIOdata,
  output logic [gpioCmdPkg::RDATA_W-1:0] o_GPIOdata,
  output logic [2:0]                     o_led,
  output logic                           o_EoP_MCU
);
  import convPkg::*;

  // Control to engine
  logic [N_TAPS*TAP_W-1:0] taps;
  logic                    kernelValid;
  logic [ADDR_W-1:0]       imgLength;
  logic                    sop;
  logic                    eop;
  // Host side of the buffer
  logic                    pixWrEn;
  logic [ADDR_W-1:0]       pixWrAddr;
  logic [PIX_W-1:0]        pixWrData;
  logic [ADDR_W-1:0]       resRdAddr;
  logic [RES_W-1:0]        resRdData;
  // Engine side of the buffer
  logic [ADDR_W-1:0]       pixRdAddr;
  logic [PIX_W-1:0]        pixRdData;
  logic                    resWrEn;
  logic [ADDR_W-1:0]       resWrAddr;
  logic [RES_W-1:0]        resWrData;

  controlBlock ctrlBlk (
    .i_CLK(i_CLK), .i_rst(i_rst),
    .i_GPIOctrl(i_GPIOctrl), .i_GPIOvalid(i_GPIOvalid), .i_GPIOdata(i_GPIOdata),
    .i_eop(eop), .i_resRdData(resRdData),
    .o_GPIOdata(o_GPIOdata), .o_led(o_led), .o_EoP_MCU(o_EoP_MCU),
    .o_taps(taps), .o_kernelValid(kernelValid), .o_imgLength(imgLength),
    .o_pixWrEn(pixWrEn), .o_pixWrAddr(pixWrAddr), .o_pixWrData(pixWrData),
    .o_resRdAddr(resRdAddr), .o_sop(sop)
  );

  pixelBuffer pixBuf (
    .i_CLK(i_CLK),
    .i_pixWrEn(pixWrEn), .i_pixWrAddr(pixWrAddr), .i_pixWrData(pixWrData),
    .i_pixRdAddr(pixRdAddr),
    .i_resWrEn(resWrEn), .i_resWrAddr(resWrAddr), .i_resWrData(resWrData),
    .i_resRdAddr(resRdAddr),
    .o_pixRdData(pixRdData), .o_resRdData(resRdData)
  );

  convEngine convEng (
    .i_CLK(i_CLK), .i_rst(i_rst), .i_sop(sop),
    .i_taps(taps), .i_kernelValid(kernelValid), .i_imgLength(imgLength),
    .i_pixRdData(pixRdData), .o_pixRdAddr(pixRdAddr),
    .o_resWrEn(resWrEn), .o_resWrAddr(resWrAddr), .o_resWrData(resWrData),
    .o_eop(eop)
  );

endmodule

`default_nettype wire

//--- rtl/convEngine.sv
`default_nettype none
`timescale 1ns/100ps

module convEngine (
  input  logic                                      i_CLK,
  input  logic                                      i_rst,
  input  logic                                      i_sop,
  input  logic [convPkg::N_TAPS*convPkg::TAP_W-1:0] i_taps,
  input  logic                                      i_kernelValid,
  input  logic [convPkg::ADDR_W-1:0]                i_imgLength,
  input  logic [convPkg::PIX_W-1:0]                 i_pixRdData,
  output logic [convPkg::ADDR_W-1:0]                o_pixRdAddr,
  output logic                                      o_resWrEn,
  output logic [convPkg::ADDR_W-1:0]                o_resWrAddr,
  output logic [convPkg::RES_W-1:0]                 o_resWrData,
  output logic                                      o_eop
);
  import convPkg::*;

  logic [N_TAPS-1:0][TAP_W-1:0]   tapReg;
  // Index 0 holds the newest pixel
  logic [N_TAPS-1:0][PIX_W-1:0]   win;
  logic [N_TAPS-1:0]              winVld;
  logic                           sopPrev;
  logic                           startPulse;
  logic                           reading;
  logic                           rdVld;
  logic [ADDR_W-1:0]              rdAddr;
  logic [ADDR_W-1:0]              lenReg;
  logic [ADDR_W-1:0]              resCnt;
  logic [RES_SHIFT+RES_W-1:0]     sumNext;
  logic [RES_SHIFT+RES_W-1:0]     sumReg;
  logic                           sumVld;
  logic                           lastWr;

  assign startPulse = i_sop & ~sopPrev;

  // Kernel held for the whole run
  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      tapReg <= '0;
    end else if (i_kernelValid) begin
      tapReg <= i_taps;
    end
  end

  ////////////////////////////////////////
  // Read sequencer
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      sopPrev <= 1'b0;
      reading <= 1'b0;
      rdAddr  <= '0;
      rdVld   <= 1'b0;
    end else begin
      sopPrev <= i_sop;
      // Buffer data shows up one cycle after the address
      rdVld   <= reading;
      if (startPulse) begin
        rdAddr  <= '0;
        // Too short for a single window
        reading <= (i_imgLength >= ADDR_W'(N_TAPS));
      end else if (reading) begin
        rdAddr <= rdAddr + 1'b1;
        if (rdAddr == lenReg - 1'b1) begin
          reading <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_CLK) begin
    if (startPulse) begin
      lenReg <= i_imgLength;
    end
  end

  ////////////////////////////////////////
  // Window and multiply-add
  ////////////////////////////////////////

  // Free-running shift, validity tracked alongside
  always_ff @(posedge i_CLK) begin
    win <= {win[N_TAPS-2:0], i_pixRdData};
  end

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      winVld <= '0;
      sumVld <= 1'b0;
    end else begin
      winVld <= {winVld[N_TAPS-2:0], rdVld};
      // Window complete once every slot came from this run
      sumVld <= &winVld;
    end
  end

  // Tap 0 weights the oldest pixel
  always_comb begin
    sumNext = '0;
    for (int k = 0; k < N_TAPS; k++) begin
      sumNext = sumNext + tapReg[k] * win[N_TAPS-1-k];
    end
  end

  always_ff @(posedge i_CLK) begin
    sumReg <= sumNext;
  end

  ////////////////////////////////////////
  // Result write and end of process
  ////////////////////////////////////////

  assign lastWr = sumVld && (resCnt == lenReg - ADDR_W'(N_TAPS));

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      resCnt <= '0;
      o_eop  <= 1'b0;
    end else begin
      if (startPulse) begin
        resCnt <= '0;
      end else if (sumVld) begin
        resCnt <= resCnt + 1'b1;
      end
      // Short image ends at once
      o_eop <= (startPulse && (i_imgLength < ADDR_W'(N_TAPS))) || lastWr;
    end
  end

  assign o_pixRdAddr = rdAddr;
  assign o_resWrEn   = sumVld;
  assign o_resWrAddr = resCnt;
  assign o_resWrData = sumReg[RES_SHIFT +: RES_W];

endmodule

`default_nettype wire

//--- rtl/pixelBuffer.sv
`default_nettype none
`timescale 1ns/100ps

module pixelBuffer (
  input  logic                       i_CLK,
  input  logic                       i_pixWrEn,
  input  logic [convPkg::ADDR_W-1:0] i_pixWrAddr,
  input  logic [convPkg::PIX_W-1:0]  i_pixWrData,
  input  logic [convPkg::ADDR_W-1:0] i_pixRdAddr,
  input  logic                       i_resWrEn,
  input  logic [convPkg::ADDR_W-1:0] i_resWrAddr,
  input  logic [convPkg::RES_W-1:0]  i_resWrData,
  input  logic [convPkg::ADDR_W-1:0] i_resRdAddr,
  output logic [convPkg::PIX_W-1:0]  o_pixRdData,
  output logic [convPkg::RES_W-1:0]  o_resRdData
);
  import convPkg::*;

  // Pixel bank, written by host, read by engine
  logic [PIX_W-1:0] pixMem [DEPTH];
  // Result bank, written by engine, read by host
  logic [RES_W-1:0] resMem [DEPTH];

  // Registered read, old data on a same-address write
  always_ff @(posedge i_CLK) begin
    if (i_pixWrEn) begin
      pixMem[i_pixWrAddr] <= i_pixWrData;
    end
    o_pixRdData <= pixMem[i_pixRdAddr];
  end

  always_ff @(posedge i_CLK) begin
    if (i_resWrEn) begin
      resMem[i_resWrAddr] <= i_resWrData;
    end
    o_resRdData <= resMem[i_resRdAddr];
  end

endmodule

`default_nettype wire

//--- rtl/controlBlock.sv
`default_nettype none
`timescale 1ns/100ps

module controlBlock (
  input  logic                                      i_CLK,
  input  logic                                      i_rst,
  input  logic [gpioCmdPkg::CMD_W-1:0]              i_GPIOctrl,
  input  logic                                      i_GPIOvalid,
  input  logic [gpioCmdPkg::DATA_W-1:0]             i_GPIOdata,
  input  logic                                      i_eop,
  input  logic [convPkg::RES_W-1:0]                 i_resRdData,
  output logic [gpioCmdPkg::RDATA_W-1:0]            o_GPIOdata,
  output logic [2:0]                                o_led,
  output logic                                      o_EoP_MCU,
  output logic [convPkg::N_TAPS*convPkg::TAP_W-1:0] o_taps,
  output logic                                      o_kernelValid,
  output logic [convPkg::ADDR_W-1:0]                o_imgLength,
  output logic                                      o_pixWrEn,
  output logic [convPkg::ADDR_W-1:0]                o_pixWrAddr,
  output logic [convPkg::PIX_W-1:0]                 o_pixWrData,
  output logic [convPkg::ADDR_W-1:0]                o_resRdAddr,
  output logic                                      o_sop
);
  import gpioCmdPkg::*;
  import convPkg::*;

  gpioData_u         hostData;
  logic              validPrev;
  logic              validRise;
  logic              isReq;
  logic [ADDR_W-1:0] wrPtr;
  logic              running;
  logic              done;
  logic              kernelMode;
  logic [DATA_W-1:0] dataDly;
  logic              reqDly;

  assign hostData  = i_GPIOdata;
  // Valid low at last edge, high now
  assign validRise = i_GPIOvalid & ~validPrev;
  assign isReq     = (i_GPIOctrl == CMD_DATA_REQ);

  ////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_rst) begin
      validPrev     <= 1'b0;
      o_taps        <= '0;
      o_kernelValid <= 1'b0;
      o_imgLength   <= '0;
      o_pixWrEn     <= 1'b0;
      wrPtr         <= '0;
      running       <= 1'b0;
      done          <= 1'b0;
      kernelMode    <= 1'b1;
    end else begin
      validPrev     <= i_GPIOvalid;
      // Strobes default low
      o_kernelValid <= 1'b0;
      o_pixWrEn     <= 1'b0;
      // Advance after each pixel write
      if (o_pixWrEn) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (!running) begin
        case (i_GPIOctrl)
          CMD_KERNEL_LOAD: begin
            // Taps track the field, engine latches on the strobe
            kernelMode    <= 1'b1;
            done          <= 1'b0;
            o_taps        <= hostData.taps;
            o_kernelValid <= validRise;
          end
          CMD_SIZE_LOAD: begin
            kernelMode  <= 1'b0;
            o_imgLength <= hostData.length.value;
            wrPtr       <= '0;
          end
          CMD_IMG_LOAD: begin
            kernelMode <= 1'b0;
            o_pixWrEn  <= validRise;
          end
          CMD_START: begin
            // Edge qualified so a held command cannot restart
            if (validRise) begin
              running <= 1'b1;
              done    <= 1'b0;
            end
          end
          default: ;
        endcase
      end else if (i_eop) begin
        // Engine hands control back
        running <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

  // Pixel captured at the valid edge
  always_ff @(posedge i_CLK) begin
    if (validRise) begin
      o_pixWrData <= hostData.pixel.value;
    end
  end

  ////////////////////////////////////////
  // Readback path
  ////////////////////////////////////////

  // Second stage lines up with the buffer's registered read
  always_ff @(posedge i_CLK) begin
    dataDly    <= i_GPIOdata;
    reqDly     <= isReq;
    o_GPIOdata <= reqDly ? {{(RDATA_W-RES_W){1'b0}}, i_resRdData}
                         : {{(RDATA_W-DATA_W){1'b0}}, dataDly};
  end

  assign o_resRdAddr = isReq ? hostData.address.value : '0;
  assign o_pixWrAddr = wrPtr;
  assign o_sop       = running;
  assign o_EoP_MCU   = done;
  // Kernel mode, done, running
  assign o_led       = {kernelMode, done, running};

endmodule

`default_nettype wire

//--- rtl/gpioCmdPkg.sv
`default_nettype none

package gpioCmdPkg;

  ////////////////////////////////////////
  // Host port widths
  ////////////////////////////////////////

  // Command code carried next to the valid bit
  localparam int CMD_W   = 3;
  // Data field written by the host
  localparam int DATA_W  = 24;
  // Readback word returned to the host
  localparam int RDATA_W = 32;

  ////////////////////////////////////////
  // Command codes
  ////////////////////////////////////////

  localparam logic [CMD_W-1:0] CMD_KERNEL_LOAD = 3'd0;
  localparam logic [CMD_W-1:0] CMD_SIZE_LOAD   = 3'd1;
  localparam logic [CMD_W-1:0] CMD_IMG_LOAD    = 3'd2;
  localparam logic [CMD_W-1:0] CMD_DATA_REQ    = 3'd3;
  localparam logic [CMD_W-1:0] CMD_START       = 3'd4;
  // Codes 5 to 7 are spare and decode to nothing

  // Data field as seen by each command
  typedef union packed {
    // Kernel load, tap 0 in the low byte
    logic [convPkg::N_TAPS-1:0][convPkg::TAP_W-1:0] taps;
    // Image load
    struct packed {
      logic [DATA_W-convPkg::PIX_W-1:0] rsvd;
      logic [convPkg::PIX_W-1:0]        value;
    } pixel;
    // Size load
    struct packed {
      logic [DATA_W-convPkg::ADDR_W-1:0] rsvd;
      logic [convPkg::ADDR_W-1:0]        value;
    } length;
    // Data request
    struct packed {
      logic [DATA_W-convPkg::ADDR_W-1:0] rsvd;
      logic [convPkg::ADDR_W-1:0]        value;
    } address;
  } gpioData_u;

endpackage

`default_nettype wire

//--- rtl/convPkg.sv
`default_nettype none

package convPkg;

  // Pixel and tap widths, both unsigned
  localparam int PIX_W     = 8;
  localparam int TAP_W     = 8;
  // Address and image length width
  localparam int ADDR_W    = 11;
  // Words per bank
  localparam int DEPTH     = 1 << ADDR_W;
  // Raw sum scaling
  localparam int RES_SHIFT = 5;
  // 3*255*255 >> 5 = 6096 fits here
  localparam int RES_W     = 13;
  // Kernel size
  localparam int N_TAPS    = 3;

endpackage

`default_nettype wire
